//--- Makefile
# Verilator build and run for the RIB crossbar

VERILATOR ?= verilator
TOP       ?= rib_tb
FILELIST  ?= rib.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
EXTRA     ?=
PASS_MSG  ?= Test passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS EXTRA"

# the run passes only if the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/rib_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module rib_arbiter (
    input  wire logic                                  arst_n_i,
    input  wire logic [rib_cfg_pkg::RIB_N_MASTERS-1:0] req_i,
    output rib_bus_pkg::rib_master_e                   grant_o,
    output logic                                       hold_o
);

    import rib_cfg_pkg::*;

    logic [RIB_N_MASTERS-1:0] req_act;      // requests seen outside reset

    // nothing competes for the bus while reset is low
    assign req_act = arst_n_i ? req_i : '0;

    // Fixed priority, highest first: master 3, master 0, master 2.
    // Master 1 keeps the bus whenever none of them asks.
    always_comb begin
        if (req_act[rib_bus_pkg::MASTER_3]) begin
            grant_o = rib_bus_pkg::MASTER_3;
        end else if (req_act[rib_bus_pkg::MASTER_0]) begin
            grant_o = rib_bus_pkg::MASTER_0;
        end else if (req_act[rib_bus_pkg::MASTER_2]) begin
            grant_o = rib_bus_pkg::MASTER_2;
        end else begin
            grant_o = rib_bus_pkg::MASTER_1;   // default owner
        end
    end

    // stall the pipeline while another master holds the bus
    assign hold_o = (grant_o != rib_bus_pkg::MASTER_1);

endmodule

`default_nettype wire

//--- logic/rib_bus_pkg.sv
`default_nettype none

package rib_bus_pkg;

    import rib_cfg_pkg::*;

    // one request as driven by a master, or as seen by a slave
    typedef struct packed {
        logic                  req;         // access request
        logic                  we;          // 1 write, 0 read
        logic [RIB_ADDR_W-1:0] addr;        // slave sees region bits cleared
        logic [RIB_DATA_W-1:0] wdata;       // write data
    } rib_req_t;

    // one response as driven by a slave, or as seen by a master
    typedef struct packed {
        logic                  ack;         // access complete
        logic [RIB_DATA_W-1:0] rdata;       // valid with ack on a read
    } rib_rsp_t;

    // idle values on the bus
    localparam rib_req_t RIB_REQ_IDLE = '0;
    localparam rib_rsp_t RIB_RSP_IDLE = '0;

    // Masters on the crossbar. MASTER_1 owns the bus by default, the
    // others win in the order 3, 0, 2 and stall the pipeline while they do.
    typedef enum logic [RIB_MASTER_W-1:0] {
        MASTER_0 = 2'd0,
        MASTER_1 = 2'd1,                    // default owner
        MASTER_2 = 2'd2,
        MASTER_3 = 2'd3                     // highest priority
    } rib_master_e;

endpackage

`default_nettype wire

//--- logic/rib_cfg_pkg.sv
`default_nettype none

package rib_cfg_pkg;

    // bus widths
    localparam int RIB_ADDR_W = 32;         // byte address
    localparam int RIB_DATA_W = 32;         // one word per access

    // crossbar size
    localparam int RIB_N_MASTERS = 4;       // core fetch, core lsu, dma, debug
    localparam int RIB_N_SLAVES  = 6;       // regions 0 to 5 are mapped

    // The region field sits in the top address bits and picks a slave.
    // With 4 bits there is room for 16 regions, only the first six are used.
    localparam int RIB_REGION_W   = 4;
    localparam int RIB_REGION_LSB = RIB_ADDR_W - RIB_REGION_W;  // bit 28

    // index of a mapped slave
    localparam int RIB_SLAVE_IDX_W = 3;     // enough for six slaves

    // grant width
    localparam int RIB_MASTER_W = $clog2(RIB_N_MASTERS);

endpackage

`default_nettype wire

//--- logic/rib_req_router.sv
`default_nettype none
`timescale 1ns/1ns

module rib_req_router (
    input  wire logic                         arst_n_i,
    input  wire rib_bus_pkg::rib_master_e     grant_i,
    input  wire rib_bus_pkg::rib_req_t [rib_cfg_pkg::RIB_N_MASTERS-1:0] m_req_i,
    output rib_bus_pkg::rib_req_t [rib_cfg_pkg::RIB_N_SLAVES-1:0]       s_req_o,
    output logic [rib_cfg_pkg::RIB_SLAVE_IDX_W-1:0]                     slave_idx_o,
    output logic                                                        hit_o
);

    import rib_cfg_pkg::*;
    import rib_bus_pkg::*;

    rib_req_t                win_req;       // request of the granted master
    rib_req_t                fwd_req;       // same request as the slave sees it
    logic [RIB_REGION_W-1:0] region;        // top address bits

    // request mux
    assign win_req = m_req_i[grant_i];

    // region decoded once for both directions
    assign region = win_req.addr[RIB_ADDR_W-1:RIB_REGION_LSB];

    // regions 6 to 15 reach no slave
    assign hit_o = arst_n_i && (region < RIB_REGION_W'(RIB_N_SLAVES));

    assign slave_idx_o = region[RIB_SLAVE_IDX_W-1:0];

    // slaves see an offset within their own region
    always_comb begin
        fwd_req = win_req;
        fwd_req.addr[RIB_ADDR_W-1:RIB_REGION_LSB] = '0;
    end

    // Only the decoded slave gets the request. The forwarded req bit is
    // the master's own, so the default owner that is not asking shows
    // address and data to its slave with req low.
    always_comb begin
        for (int s = 0; s < RIB_N_SLAVES; s++) begin
            if (hit_o && (slave_idx_o == RIB_SLAVE_IDX_W'(s))) begin
                s_req_o[s] = fwd_req;
            end else begin
                s_req_o[s] = RIB_REQ_IDLE;      // idle slave
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rib_rsp_router.sv
`default_nettype none
`timescale 1ns/1ns

module rib_rsp_router (
    input  wire rib_bus_pkg::rib_master_e                              grant_i,
    input  wire logic [rib_cfg_pkg::RIB_SLAVE_IDX_W-1:0]               slave_idx_i,
    input  wire logic                                                  hit_i,
    input  wire rib_bus_pkg::rib_rsp_t [rib_cfg_pkg::RIB_N_SLAVES-1:0] s_rsp_i,
    output rib_bus_pkg::rib_rsp_t [rib_cfg_pkg::RIB_N_MASTERS-1:0]     m_rsp_o
);

    import rib_cfg_pkg::*;
    import rib_bus_pkg::*;

    rib_rsp_t sel_rsp;                      // response of the addressed slave

    // Pick the addressed slave. A miss leaves the response idle, and
    // so does reset, since the request router holds hit low then.
    always_comb begin
        sel_rsp = RIB_RSP_IDLE;
        for (int s = 0; s < RIB_N_SLAVES; s++) begin
            if (hit_i && (slave_idx_i == RIB_SLAVE_IDX_W'(s))) begin
                sel_rsp = s_rsp_i[s];
            end
        end
    end

    // back to the granted master only
    always_comb begin
        for (int m = 0; m < RIB_N_MASTERS; m++) begin
            if (grant_i == rib_master_e'(m)) begin
                m_rsp_o[m] = sel_rsp;
            end else begin
                m_rsp_o[m] = RIB_RSP_IDLE;      // losers see no ack, zero data
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rib_top.sv
`default_nettype none
`timescale 1ns/1ns

module rib_top (
    input  wire logic                                                  arst_n_i,

    // masters
    input  wire rib_bus_pkg::rib_req_t [rib_cfg_pkg::RIB_N_MASTERS-1:0] m_req_i,
    output rib_bus_pkg::rib_rsp_t [rib_cfg_pkg::RIB_N_MASTERS-1:0]      m_rsp_o,

    // slaves
    output rib_bus_pkg::rib_req_t [rib_cfg_pkg::RIB_N_SLAVES-1:0]       s_req_o,
    input  wire rib_bus_pkg::rib_rsp_t [rib_cfg_pkg::RIB_N_SLAVES-1:0]  s_rsp_i,

    // pipeline stall
    output logic                                                       hold_o
);

    import rib_cfg_pkg::*;
    import rib_bus_pkg::*;

    logic [RIB_N_MASTERS-1:0]   m_req_bits;     // req bit of each master
    rib_master_e                grant;          // current bus owner
    logic [RIB_SLAVE_IDX_W-1:0] slave_idx;      // decoded slave
    logic                       slave_hit;      // region is mapped

    // the arbiter only needs the req bits
    for (genvar m = 0; m < RIB_N_MASTERS; m++) begin : g_req_bits
        assign m_req_bits[m] = m_req_i[m].req;
    end

    rib_arbiter i_arbiter (
        .arst_n_i (arst_n_i),
        .req_i    (m_req_bits),
        .grant_o  (grant),
        .hold_o   (hold_o)
    );

    // master to slave
    rib_req_router i_req_router (
        .arst_n_i    (arst_n_i),
        .grant_i     (grant),
        .m_req_i     (m_req_i),
        .s_req_o     (s_req_o),
        .slave_idx_o (slave_idx),
        .hit_o       (slave_hit)
    );

    // slave to master, reuses the decode above
    rib_rsp_router i_rsp_router (
        .grant_i     (grant),
        .slave_idx_i (slave_idx),
        .hit_i       (slave_hit),
        .s_rsp_i     (s_rsp_i),
        .m_rsp_o     (m_rsp_o)
    );

endmodule

`default_nettype wire

//--- rib.f
logic/rib_cfg_pkg.sv
logic/rib_bus_pkg.sv
logic/rib_arbiter.sv
logic/rib_req_router.sv
logic/rib_rsp_router.sv
logic/rib_top.sv
verif/rib_clk_gen.sv
verif/rib_props.sv
verif/rib_tb.sv

//--- verif/rib_clk_gen.sv
`default_nettype none
`timescale 1ns/1ns

module rib_clk_gen (
    output logic clk_o
);

    localparam int HALF_PERIOD = 2;     // 4 ns period

    initial begin
        clk_o = 1'b0;                   // first rising edge at 2 ns
        forever begin
            #(HALF_PERIOD);
            clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- verif/rib_props.sv
`default_nettype none
`timescale 1ns/1ns

module rib_props (
    input wire logic                                                   clk_i,
    input wire logic                                                   arst_n_i,
    input wire rib_bus_pkg::rib_req_t [rib_cfg_pkg::RIB_N_MASTERS-1:0] m_req_i,
    input wire rib_bus_pkg::rib_rsp_t [rib_cfg_pkg::RIB_N_MASTERS-1:0] m_rsp_i,
    input wire rib_bus_pkg::rib_req_t [rib_cfg_pkg::RIB_N_SLAVES-1:0]  s_req_i,
    input wire logic                                                   hold_i
);

    import rib_cfg_pkg::*;
    import rib_bus_pkg::*;

    logic [RIB_N_SLAVES-1:0]  s_req_bits;       // req bit of each slave
    logic [RIB_N_SLAVES-1:0]  s_region_set;     // slave addr with region bits left
    logic [RIB_N_MASTERS-1:0] m_ack_bits;       // ack bit of each master

    always_comb begin
        for (int s = 0; s < RIB_N_SLAVES; s++) begin
            s_req_bits[s]   = s_req_i[s].req;
            s_region_set[s] = |s_req_i[s].addr[RIB_ADDR_W-1 -: RIB_REGION_W];
        end
        for (int m = 0; m < RIB_N_MASTERS; m++) begin
            m_ack_bits[m] = m_rsp_i[m].ack;
        end
    end

    a_one_slave_req: assert property (@(posedge clk_i) $onehot0(s_req_bits))
        else $error("more than one slave request at once: %b", s_req_bits);

    // only the default owner runs without a stall
    a_hold_match: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        hold_i == (m_req_i[0].req | m_req_i[2].req | m_req_i[3].req))
        else $error("hold does not follow the requests of masters 0, 2 and 3");

    a_region_cleared: assert property (@(posedge clk_i) s_region_set == '0)
        else $error("slave address keeps region bits: %b", s_region_set);

    a_quiet_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> (s_req_bits == '0 && m_ack_bits == '0 && !hold_i))
        else $error("bus activity while reset is low");

endmodule

`default_nettype wire

//--- verif/rib_tb.sv
`default_nettype none
`timescale 1ns/1ns

module rib_tb;

    import rib_cfg_pkg::*;
    import rib_bus_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h24750661;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
    localparam int N_ROWS       = 22;
    localparam int RESET_CYCLES = 2;
    localparam int ACK_TIMEOUT  = 16;    // cycles
    localparam int DRIVE_DLY    = 1;     // ns after the rising edge
    localparam int CHECK_DLY    = 2;     // ns after driving and just before the next edge
    localparam int CHK_W        = $bits(rib_req_t);

    typedef struct packed {
        logic [RIB_N_MASTERS-1:0]                   req_mask;
        logic [RIB_N_MASTERS-1:0][RIB_REGION_W-1:0] regions;   // master 3 in top nibble
        logic [RIB_N_MASTERS-1:0]                   we_mask;
        logic [RIB_N_SLAVES-1:0]                    ack_mask;  // slaves that answer
    } stim_row_t;

    // Every request mask appears once in rows 0 to 15, and the winners
    // address all sixteen regions across the whole table.
    localparam stim_row_t STIM_TABLE [N_ROWS] = '{
        '{4'b0000, 16'h5432, 4'b0000, 6'h3F},   // master 1 owns region 3 while idle
        '{4'b0001, 16'h1234, 4'b0001, 6'h3F},
        '{4'b0010, 16'h0050, 4'b0010, 6'h3F},
        '{4'b0011, 16'h3321, 4'b0000, 6'h3F},
        '{4'b0100, 16'h0200, 4'b0100, 6'h3B},   // slave 2 stays silent
        '{4'b0101, 16'h0106, 4'b0001, 6'h3F},   // master 0 misses
        '{4'b0110, 16'h0070, 4'b0110, 6'h3F},
        '{4'b0111, 16'h0834, 4'b0000, 6'h3F},
        '{4'b1000, 16'h8000, 4'b1000, 6'h3F},
        '{4'b1001, 16'h1009, 4'b1001, 6'h3D},   // slave 1 stays silent
        '{4'b1010, 16'h2000, 4'b0000, 6'h3F},
        '{4'b1011, 16'h3000, 4'b1011, 6'h3F},
        '{4'b1100, 16'h4500, 4'b1100, 6'h3F},
        '{4'b1101, 16'h5000, 4'b0101, 6'h3F},
        '{4'b1110, 16'hA000, 4'b1110, 6'h3F},
        '{4'b1111, 16'hF000, 4'b1111, 6'h3F},
        '{4'b0001, 16'h000B, 4'b0001, 6'h3F},
        '{4'b0100, 16'h0C00, 4'b0000, 6'h3F},
        '{4'b0001, 16'h000D, 4'b0000, 6'h3F},
        '{4'b0100, 16'h0E00, 4'b0100, 6'h3F},
        '{4'b0010, 16'h0070, 4'b0010, 6'h3F},   // master 1 misses
        '{4'b0010, 16'h0090, 4'b0000, 6'h3F}
    };

    logic                         clk;
    logic                         arst_n;
    rib_req_t [RIB_N_MASTERS-1:0] m_req;
    rib_rsp_t [RIB_N_MASTERS-1:0] m_rsp;
    rib_req_t [RIB_N_SLAVES-1:0]  s_req;
    rib_rsp_t [RIB_N_SLAVES-1:0]  s_rsp;
    logic                         hold;

    rib_req_t [RIB_N_SLAVES-1:0]  exp_s_req;
    rib_rsp_t [RIB_N_MASTERS-1:0] exp_m_rsp;
    logic                         exp_hold;

    logic [31:0] lfsr_state;
    int          err_value;             // wrong output values
    int          err_other;             // missing acknowledges

    rib_clk_gen i_clk_gen (
        .clk_o (clk)
    );

    rib_top i_dut (
        .arst_n_i (arst_n),
        .m_req_i  (m_req),
        .m_rsp_o  (m_rsp),
        .s_req_o  (s_req),
        .s_rsp_i  (s_rsp),
        .hold_o   (hold)
    );

    bind rib_top rib_props i_props (
        .clk_i    (rib_tb.clk),
        .arst_n_i (arst_n_i),
        .m_req_i  (m_req_i),
        .m_rsp_i  (m_rsp_o),
        .s_req_i  (s_req_o),
        .hold_i   (hold_o)
    );

    // one step of the Galois LFSR
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // n fresh bits with one LFSR step for each
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // priority order 3, 0, 2, then the default owner
    function automatic int predict_winner(input logic [RIB_N_MASTERS-1:0] mask);
        if (mask[3]) begin
            return 3;
        end else if (mask[0]) begin
            return 0;
        end else if (mask[2]) begin
            return 2;
        end
        return 1;
    endfunction

    task automatic compute_expected();
        logic [RIB_N_MASTERS-1:0] mask;
        rib_req_t                 fwd;
        int                       win;
        int                       sidx;
        exp_s_req = '0;
        exp_m_rsp = '0;
        exp_hold  = 1'b0;
        if (arst_n) begin
            for (int m = 0; m < RIB_N_MASTERS; m++) begin
                mask[m] = m_req[m].req;
            end
            win      = predict_winner(mask);
            exp_hold = mask[0] | mask[2] | mask[3];
            sidx     = int'(m_req[win].addr[RIB_ADDR_W-1 -: RIB_REGION_W]);
            if (sidx < RIB_N_SLAVES) begin          // mapped region
                fwd = m_req[win];
                fwd.addr[RIB_ADDR_W-1 -: RIB_REGION_W] = '0;
                exp_s_req[sidx] = fwd;
                exp_m_rsp[win]  = s_rsp[sidx];
            end
        end
    endtask

    task automatic check_value(input string name, input logic [CHK_W-1:0] exp_val,
                               input logic [CHK_W-1:0] act_val);
        assert (act_val === exp_val) else begin
            err_value++;
            $display("Fail: time %0t, %s expected %h, actual %h", $time, name, exp_val,
                     act_val);
        end
    endtask

    task automatic check_outputs();
        compute_expected();
        check_value("hold_o", CHK_W'(exp_hold), CHK_W'(hold));
        for (int s = 0; s < RIB_N_SLAVES; s++) begin
            check_value($sformatf("s_req_o[%0d]", s), CHK_W'(exp_s_req[s]), CHK_W'(s_req[s]));
        end
        for (int m = 0; m < RIB_N_MASTERS; m++) begin
            check_value($sformatf("m_rsp_o[%0d]", m), CHK_W'(exp_m_rsp[m]), CHK_W'(m_rsp[m]));
        end
    endtask

    task automatic next_drive();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    // masters from the row with random offsets and data while slaves stay silent
    task automatic load_row(input stim_row_t row);
        logic [31:0] offset;
        for (int m = 0; m < RIB_N_MASTERS; m++) begin
            offset         = rand_bits(RIB_ADDR_W - RIB_REGION_W);
            m_req[m].req   = row.req_mask[m];
            m_req[m].we    = row.we_mask[m];
            m_req[m].addr  = {row.regions[m], offset[RIB_ADDR_W-RIB_REGION_W-1:0]};
            m_req[m].wdata = rand_bits(RIB_DATA_W);
        end
        for (int s = 0; s < RIB_N_SLAVES; s++) begin
            s_rsp[s].ack   = 1'b0;
            s_rsp[s].rdata = rand_bits(RIB_DATA_W);
        end
    endtask

    task automatic run_row(input int idx, input stim_row_t row);
        int   win;
        int   sidx;
        int   delay;
        int   waited;
        logic expect_ack;
        next_drive();
        load_row(row);
        win        = predict_winner(row.req_mask);
        sidx       = int'(row.regions[win]);
        expect_ack = 1'b0;
        if (row.req_mask[win] && sidx < RIB_N_SLAVES) begin
            expect_ack = row.ack_mask[sidx];
        end
        delay = int'(rand_bits(2));             // slave holds ack back 0 to 3 cycles
        for (int c = 0; c < delay; c++) begin
            #(CHECK_DLY);
            check_outputs();
            next_drive();
        end
        for (int s = 0; s < RIB_N_SLAVES; s++) begin
            s_rsp[s].ack = row.ack_mask[s];
        end
        #(CHECK_DLY);
        if (expect_ack) begin
            waited = 0;
            while (!m_rsp[win].ack && waited < ACK_TIMEOUT) begin
                next_drive();
                #(CHECK_DLY);
                waited++;
            end
            assert (m_rsp[win].ack) else begin
                err_other++;
                $display("row %0d: no acknowledge arrived for master %0d within %0d cycles",
                         idx, win, ACK_TIMEOUT);
            end
        end
        check_outputs();
        next_drive();                           // masters drop their requests
        m_req = '0;
        s_rsp = '0;
        #(CHECK_DLY);
        check_outputs();
    endtask

    initial begin
        err_value  = 0;
        err_other  = 0;
        lfsr_state = LFSR_SEED;
        arst_n     = 1'b0;
        m_req      = '0;
        s_rsp      = '0;

        // requests and acks pending through reset
        load_row(STIM_TABLE[9]);
        for (int s = 0; s < RIB_N_SLAVES; s++) begin
            s_rsp[s].ack = 1'b1;
        end
        #(CHECK_DLY - DRIVE_DLY);               // just before the first edge
        check_outputs();
        for (int c = 1; c < RESET_CYCLES; c++) begin
            next_drive();
            #(CHECK_DLY);
            check_outputs();
        end
        next_drive();
        arst_n = 1'b1;
        #(CHECK_DLY);
        check_outputs();                        // pending request now routed
        next_drive();
        m_req = '0;
        s_rsp = '0;

        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r, STIM_TABLE[r]);
        end

        $display("checks done: %0d wrong values, %0d other errors", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
